//--- logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Core sizing shared by the package and the RTL

// Width of a data byte, a register and the ALU
`define CPU_DATA_W 8

// Width of the fetch address and the program counter
`define CPU_ADDR_W 16

// General registers A to D
`define CPU_NUM_REGS 4

// Address of the first instruction fetched after reset
`define CPU_RESET_PC 16'h0000

`endif

//--- logic/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  // Register index, 0=A 1=B 2=C 3=D
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_sel_t;

  typedef enum logic [2:0] {
    add    = 3'd0,
    adc    = 3'd1,
    sub    = 3'd2,
    sbb    = 3'd3,
    and_op = 3'd4,
    or_op  = 3'd5,
    xor_op = 3'd6,
    cmp    = 3'd7
  } alu_op_t;

  // Kinds 4 to 7 are reserved and behave as nop
  typedef enum logic [2:0] {
    nop  = 3'd0,
    mov  = 3'd1,
    ldi  = 3'd2,
    halt = 3'd3
  } move_kind_t;

  // Bit 7 set selects the ALU view
  typedef struct packed {
    logic     fmt;
    alu_op_t  op;
    reg_sel_t dst;
    reg_sel_t src;
  } alu_insn_t;

  typedef struct packed {
    logic       fmt;
    move_kind_t kind;
    reg_sel_t   dst;
    reg_sel_t   src;
  } move_insn_t;

  typedef union packed {
    alu_insn_t  alu;
    move_insn_t move;
  } insn_t;

  typedef struct packed {
    logic negative;
    logic carry;
  } flags_t;

  typedef struct packed {
    logic                  valid;
    logic [`CPU_DATA_W-1:0] data;
  } fetch_byte_t;

  typedef struct packed {
    logic                  valid;
    logic                  is_alu;
    alu_op_t               op;
    reg_sel_t              dst;
    reg_sel_t              src;
    logic                  use_imm;
    logic [`CPU_DATA_W-1:0] imm;
    logic                  halt;
  } exec_ctrl_t;

  typedef struct packed {
    logic                  we;
    reg_sel_t              dst;
    logic [`CPU_DATA_W-1:0] data;
  } wb_t;

  typedef struct packed {
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] b;
    logic [`CPU_DATA_W-1:0] c;
    logic [`CPU_DATA_W-1:0] d;
  } reg_view_t;

  // AXI4-Lite read channels only, the core never writes
  typedef struct packed {
    logic                  arvalid;
    logic [`CPU_ADDR_W-1:0] araddr;
    logic                  rready;
  } axi_rd_req_t;

  typedef struct packed {
    logic                  arready;
    logic                  rvalid;
    logic [`CPU_DATA_W-1:0] rdata;
  } axi_rd_rsp_t;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu (
  input  logic [`CPU_DATA_W-1:0] lhs,
  input  logic [`CPU_DATA_W-1:0] rhs,
  input  cpu_pkg::alu_op_t       op,
  input  logic                   carry_in,
  output logic [`CPU_DATA_W-1:0] result,
  output cpu_pkg::flags_t        flags_out
);

  // Extra top bit holds carry out or borrow
  logic [`CPU_DATA_W:0] wide;

  always_comb begin
    wide = '0;
    case (op)
      cpu_pkg::add: begin
        wide = {1'b0, lhs} + {1'b0, rhs};
      end
      cpu_pkg::adc: begin
        wide = {1'b0, lhs} + {1'b0, rhs} + carry_in;
      end
      cpu_pkg::sub,
      cpu_pkg::cmp: begin
        wide = {1'b0, lhs} - {1'b0, rhs};
      end
      cpu_pkg::sbb: begin
        wide = {1'b0, lhs} - {1'b0, rhs} - carry_in;
      end
      // Logic ops leave the top bit clear, so carry is cleared
      cpu_pkg::and_op: begin
        wide = {1'b0, lhs & rhs};
      end
      cpu_pkg::or_op: begin
        wide = {1'b0, lhs | rhs};
      end
      cpu_pkg::xor_op: begin
        wide = {1'b0, lhs ^ rhs};
      end
      default: begin
        wide = '0;
      end
    endcase

    result             = wide[`CPU_DATA_W-1:0];
    flags_out.negative = wide[`CPU_DATA_W-1];
    flags_out.carry    = wide[`CPU_DATA_W];
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::reg_sel_t      rd_lhs,
  input  cpu_pkg::reg_sel_t      rd_rhs,
  input  cpu_pkg::wb_t           wb,
  output logic [`CPU_DATA_W-1:0] lhs_data,
  output logic [`CPU_DATA_W-1:0] rhs_data,
  output cpu_pkg::reg_view_t     regs
);

  logic [`CPU_DATA_W-1:0] regs_q [`CPU_NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb.we) begin
      regs_q[wb.dst] <= wb.data;
    end
  end

  // Read ports are combinational
  assign lhs_data = regs_q[rd_lhs];
  assign rhs_data = regs_q[rd_rhs];

  assign regs.a = regs_q[0];
  assign regs.b = regs_q[1];
  assign regs.c = regs_q[2];
  assign regs.d = regs_q[3];

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::axi_rd_rsp_t   mem_rsp,
  input  logic                   halt,
  output cpu_pkg::axi_rd_req_t   mem_req,
  output cpu_pkg::fetch_byte_t   fetch,
  output logic [`CPU_ADDR_W-1:0] pc
);

  // One read in flight at a time
  typedef enum logic {
    st_addr,
    st_data
  } rd_state_t;

  rd_state_t              state_q;
  logic                   arvalid_q;
  logic [`CPU_ADDR_W-1:0] pc_q;
  logic                   ar_done;
  logic                   r_done;

  assign ar_done = arvalid_q && mem_rsp.arready;
  assign r_done  = (state_q == st_data) && mem_rsp.rvalid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= st_addr;
      arvalid_q <= 1'b0;
      pc_q      <= `CPU_RESET_PC;
    end else begin
      case (state_q)
        st_addr: begin
          if (ar_done) begin
            state_q   <= st_data;
            arvalid_q <= 1'b0;
            pc_q      <= pc_q + 1'b1;
          end else if (!arvalid_q && !halt) begin
            // First request after reset
            arvalid_q <= 1'b1;
          end
        end
        st_data: begin
          if (r_done) begin
            state_q   <= st_addr;
            // Next address goes out right away unless the core has stopped
            arvalid_q <= !halt;
          end
        end
        default: begin
          state_q <= st_addr;
        end
      endcase
    end
  end

  // pc only moves on an AR transfer, so araddr holds while arvalid waits
  assign mem_req = '{
    arvalid: arvalid_q,
    araddr:  pc_q,
    rready:  (state_q == st_data)
  };

  assign fetch = '{
    valid: r_done,
    data:  mem_rsp.rdata
  };

  assign pc = pc_q;

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module instr_decoder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cpu_pkg::fetch_byte_t fetch,
  output cpu_pkg::exec_ctrl_t  ctrl
);

  cpu_pkg::insn_t      insn;
  cpu_pkg::insn_t      first_q;
  logic                imm_pend_q;
  logic                imm_pend_d;
  cpu_pkg::exec_ctrl_t ctrl_d;
  cpu_pkg::exec_ctrl_t ctrl_q;

  assign insn = fetch.data;

  always_comb begin
    ctrl_d     = '0;
    imm_pend_d = imm_pend_q;

    if (fetch.valid) begin
      if (imm_pend_q) begin
        // Second byte of ldi is the constant
        ctrl_d.valid   = 1'b1;
        ctrl_d.dst     = first_q.move.dst;
        ctrl_d.use_imm = 1'b1;
        ctrl_d.imm     = fetch.data;
        imm_pend_d     = 1'b0;
      end else if (insn.alu.fmt) begin
        ctrl_d.valid  = 1'b1;
        ctrl_d.is_alu = 1'b1;
        ctrl_d.op     = insn.alu.op;
        ctrl_d.dst    = insn.alu.dst;
        ctrl_d.src    = insn.alu.src;
      end else begin
        case (insn.move.kind)
          cpu_pkg::mov: begin
            ctrl_d.valid = 1'b1;
            ctrl_d.dst   = insn.move.dst;
            ctrl_d.src   = insn.move.src;
          end
          cpu_pkg::ldi: begin
            imm_pend_d = 1'b1;
          end
          cpu_pkg::halt: begin
            ctrl_d.valid = 1'b1;
            ctrl_d.halt  = 1'b1;
          end
          // nop and reserved kinds never reach execute
          default: begin
            ctrl_d.valid = 1'b0;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      imm_pend_q <= 1'b0;
      ctrl_q     <= '0;
    end else begin
      imm_pend_q <= imm_pend_d;
      ctrl_q     <= ctrl_d;
    end
  end

  // Opcode byte kept while the constant is fetched
  always_ff @(posedge clk) begin
    if (fetch.valid && !imm_pend_q) begin
      first_q <= insn;
    end
  end

  assign ctrl = ctrl_q;

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module exec_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::exec_ctrl_t    ctrl,
  input  logic [`CPU_DATA_W-1:0] lhs_data,
  input  logic [`CPU_DATA_W-1:0] rhs_data,
  output cpu_pkg::reg_sel_t      rd_lhs,
  output cpu_pkg::reg_sel_t      rd_rhs,
  output cpu_pkg::wb_t           wb,
  output cpu_pkg::flags_t        flags,
  output logic                   halt
);

  cpu_pkg::wb_t           wb_d;
  cpu_pkg::flags_t        flags_q;
  cpu_pkg::flags_t        alu_flags;
  logic                   halt_q;
  logic                   active;
  logic [`CPU_DATA_W-1:0] alu_result;

  // lhs reads dst and rhs reads src
  assign rd_lhs = ctrl.dst;
  assign rd_rhs = ctrl.src;

  // Once halted, everything coming from decode is dropped
  assign active = ctrl.valid && !halt_q;

  // Writes land in reg_file on the next edge and dependent instructions read them directly
  alu u_alu (
    .lhs       (lhs_data),
    .rhs       (rhs_data),
    .op        (ctrl.op),
    .carry_in  (flags_q.carry),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  always_comb begin
    // cmp only touches the flags
    wb_d.we  = active && !ctrl.halt && !(ctrl.is_alu && (ctrl.op == cpu_pkg::cmp));
    wb_d.dst = ctrl.dst;
    if (ctrl.use_imm) begin
      wb_d.data = ctrl.imm;
    end else if (ctrl.is_alu) begin
      wb_d.data = alu_result;
    end else begin
      wb_d.data = rhs_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags_q <= '0;
      halt_q  <= 1'b0;
    end else begin
      if (active && ctrl.is_alu) begin
        flags_q <= alu_flags;
      end
      // Sticky until reset
      if (active && ctrl.halt) begin
        halt_q <= 1'b1;
      end
    end
  end

  assign wb    = wb_d;
  assign flags = flags_q;
  assign halt  = halt_q;

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  output cpu_pkg::axi_rd_req_t   mem_req,
  input  cpu_pkg::axi_rd_rsp_t   mem_rsp,
  output cpu_pkg::reg_view_t     regs,
  output cpu_pkg::flags_t        flags,
  output logic [`CPU_ADDR_W-1:0] pc,
  output logic                   halt
);

  cpu_pkg::fetch_byte_t   fetch;
  cpu_pkg::exec_ctrl_t    ctrl;
  cpu_pkg::reg_sel_t      rd_lhs;
  cpu_pkg::reg_sel_t      rd_rhs;
  cpu_pkg::wb_t           wb;
  logic [`CPU_DATA_W-1:0] lhs_data;
  logic [`CPU_DATA_W-1:0] rhs_data;

  fetch_unit u_fetch (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_rsp (mem_rsp),
    .halt    (halt),
    .mem_req (mem_req),
    .fetch   (fetch),
    .pc      (pc)
  );

  // Stage 1
  instr_decoder u_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .fetch (fetch),
    .ctrl  (ctrl)
  );

  // Stage 2
  exec_stage u_exec (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .lhs_data (lhs_data),
    .rhs_data (rhs_data),
    .rd_lhs   (rd_lhs),
    .rd_rhs   (rd_rhs),
    .wb       (wb),
    .flags    (flags),
    .halt     (halt)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_lhs   (rd_lhs),
    .rd_rhs   (rd_rhs),
    .wb       (wb),
    .lhs_data (lhs_data),
    .rhs_data (rhs_data),
    .regs     (regs)
  );

endmodule

//--- test/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 random_delays,
  input  cpu_pkg::axi_rd_req_t mem_req,
  output cpu_pkg::axi_rd_rsp_t mem_rsp
);

  logic [7:0]           mem [256];
  logic [31:0]          lfsr = 32'h931e;
  cpu_pkg::axi_rd_rsp_t rsp;
  cpu_pkg::axi_rd_rsp_t rsp_q = '0;
  logic                 busy;
  logic                 ar_fire;
  logic                 r_fire;
  logic [7:0]           addr_q;
  logic [7:0]           rd_addr;
  int                   ar_wait;
  int                   r_wait;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Stall of 0 to 3 cycles, two LFSR bits
  task automatic draw_stall(output int n);
    n = 0;
    if (random_delays) begin
      repeat (2) begin
        n = (n << 1) | lfsr[0];
        lfsr = lfsr_next(lfsr);
      end
    end
  endtask

  task automatic write_byte(input logic [7:0] addr, input logic [7:0] data);
    mem[addr] = data;
  endtask

  // Handshakes are judged on what was driven during the last cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      rsp     = '0;
      busy    = 1'b0;
      ar_fire = 1'b0;
      r_fire  = 1'b0;
      ar_wait = -1;
    end else begin
      if (r_fire) begin
        busy       = 1'b0;
        rsp.rvalid = 1'b0;
      end
      if (ar_fire) begin
        busy        = 1'b1;
        rsp.arready = 1'b0;
        rd_addr     = addr_q;
        draw_stall(r_wait);
      end
      if (!busy && mem_req.arvalid && !rsp.arready) begin
        if (ar_wait < 0) begin
          draw_stall(ar_wait);
        end
        if (ar_wait == 0) begin
          rsp.arready = 1'b1;
          ar_wait     = -1;
        end else begin
          ar_wait--;
        end
      end
      if (busy && !rsp.rvalid) begin
        if (r_wait == 0) begin
          rsp.rvalid = 1'b1;
          rsp.rdata  = mem[rd_addr];
        end else begin
          r_wait--;
        end
      end
      ar_fire = rsp.arready && mem_req.arvalid;
      r_fire  = rsp.rvalid && mem_req.rready;
      addr_q  = mem_req.araddr[7:0];
    end
    rsp_q <= rsp;
  end

  assign mem_rsp = rsp_q;

endmodule

//--- test/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu;

  localparam int RESET_CYCLES  = 3;
  localparam int SETTLE_CYCLES = 20;
  // Idle cycle, AR stall, AR transfer, R stall and R transfer
  localparam int FETCH_WORST   = 9;
  localparam logic [1:0] RA = 2'd0;
  localparam logic [1:0] RB = 2'd1;
  localparam logic [1:0] RC = 2'd2;
  localparam logic [1:0] RD = 2'd3;

  logic                   clk = 1'b0;
  logic                   rst_n = 1'b0;
  logic                   random_delays = 1'b0;
  cpu_pkg::axi_rd_req_t   mem_req;
  cpu_pkg::axi_rd_rsp_t   mem_rsp;
  cpu_pkg::reg_view_t     regs;
  cpu_pkg::flags_t        flags;
  logic [`CPU_ADDR_W-1:0] pc;
  logic                   halt;
  logic [`CPU_ADDR_W-1:0] next_addr;
  logic [7:0]             prog [$];
  cpu_pkg::reg_view_t     exp_regs;
  cpu_pkg::flags_t        exp_flags;
  int errors = 0;
  int errors_seen = 0;
  int tests = 0;
  int failed_tests = 0;
  int cycles = 0;
  int cycle_budget = 8;

  always #4 clk = ~clk;

  cpu_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .regs    (regs),
    .flags   (flags),
    .pc      (pc),
    .halt    (halt)
  );

  tb_axi_mem mem_model (
    .clk           (clk),
    .rst_n         (rst_n),
    .random_delays (random_delays),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp)
  );

  task automatic flag_error(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    errors++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      next_addr <= `CPU_RESET_PC;
    end else if (mem_req.arvalid && mem_rsp.arready) begin
      next_addr <= next_addr + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req.arvalid && mem_rsp.arready |-> mem_req.araddr == next_addr)
    else flag_error("araddr out of order");
  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req.arvalid && !mem_rsp.arready |=> mem_req.arvalid && $stable(mem_req.araddr))
    else flag_error("AR request dropped or moved while stalled");
  assert property (@(posedge clk) disable iff (!rst_n) mem_req.rready |-> !mem_req.arvalid)
    else flag_error("second read issued while one is outstanding");
  // Once drained after halt the port stays quiet
  assert property (@(posedge clk) disable iff (!rst_n)
    halt && !mem_req.arvalid && !mem_req.rready |=> !mem_req.arvalid)
    else flag_error("fetch restarted after halt");
  assert property (@(posedge clk) disable iff (!rst_n)
    halt |=> halt && $stable(regs) && $stable(flags))
    else flag_error("regs or flags changed after halt");

  task automatic ldi_to(input logic [1:0] dst, input logic [7:0] value);
    prog.push_back({1'b0, 3'd2, dst, 2'd0});
    prog.push_back(value);
  endtask

  task automatic mov_to(input logic [1:0] dst, input logic [1:0] src);
    prog.push_back({1'b0, 3'd1, dst, src});
  endtask

  task automatic alu_do(input cpu_pkg::alu_op_t op, input logic [1:0] dst,
                        input logic [1:0] src);
    prog.push_back({1'b1, op, dst, src});
  endtask

  task automatic halt_here();
    prog.push_back({1'b0, 3'd3, 4'd0});
  endtask

  // Dependent ALU chain on immediates that two tests share
  task automatic build_alu_program();
    prog.delete();
    ldi_to(RA, 8'hF0);
    ldi_to(RB, 8'h20);
    ldi_to(RC, 8'h3C);
    alu_do(cpu_pkg::add, RA, RB);
    alu_do(cpu_pkg::adc, RA, RB);
    alu_do(cpu_pkg::sub, RB, RA);
    alu_do(cpu_pkg::sbb, RA, RB);
    alu_do(cpu_pkg::and_op, RA, RC);
    alu_do(cpu_pkg::or_op, RC, RB);
    alu_do(cpu_pkg::xor_op, RD, RC);
    alu_do(cpu_pkg::cmp, RA, RB);
    alu_do(cpu_pkg::adc, RD, RA);
    alu_do(cpu_pkg::cmp, RB, RB);
    alu_do(cpu_pkg::sbb, RC, RA);
    halt_here();
  endtask

  // Architectural model of the instruction rules
  task automatic run_model();
    logic [7:0] r [4];
    logic [7:0] b;
    logic [7:0] lhs;
    logic [7:0] rhs;
    logic [7:0] res;
    logic       cy;
    logic       neg;
    int         idx;
    int         sum;
    bit         running;
    r       = '{default: 8'h00};
    cy      = 1'b0;
    neg     = 1'b0;
    idx     = 0;
    running = 1'b1;
    while (running && idx < prog.size()) begin
      b = prog[idx];
      idx++;
      if (b[7]) begin
        lhs = r[b[3:2]];
        rhs = r[b[1:0]];
        case (b[6:4])
          3'd0: sum = int'(lhs) + int'(rhs);
          3'd1: sum = int'(lhs) + int'(rhs) + int'(cy);
          3'd2, 3'd7: sum = int'(lhs) - int'(rhs);
          3'd3: sum = int'(lhs) - int'(rhs) - int'(cy);
          3'd4: sum = int'(lhs & rhs);
          3'd5: sum = int'(lhs | rhs);
          default: sum = int'(lhs ^ rhs);
        endcase
        res = sum[7:0];
        neg = res[7];
        // Carry is the add carry out or the subtract borrow and stays clear for logic ops
        cy  = (sum < 0) || (sum > 255);
        if (b[6:4] != 3'd7) begin
          r[b[3:2]] = res;
        end
      end else begin
        case (b[6:4])
          3'd1: r[b[3:2]] = r[b[1:0]];
          3'd2: begin
            r[b[3:2]] = prog[idx];
            idx++;
          end
          3'd3: running = 1'b0;
          default: ;
        endcase
      end
    end
    exp_regs  = {r[0], r[1], r[2], r[3]};
    exp_flags = {neg, cy};
  endtask

  task automatic expect_state(input string what, input cpu_pkg::reg_view_t r,
                              input cpu_pkg::flags_t f);
    assert (regs == r && flags == f)
      else flag_error($sformatf("%s: regs %h flags %b, expected regs %h flags %b",
                                what, regs, flags, r, f));
  endtask

  task automatic run_program(input bit delays);
    cycle_budget += prog.size() * FETCH_WORST * 4 + RESET_CYCLES + SETTLE_CYCLES;
    @(negedge clk);
    for (int a = 0; a < 256; a++) begin
      mem_model.write_byte(8'(a), 8'(a * 29 + 107));
    end
    foreach (prog[i]) begin
      mem_model.write_byte(8'(i), prog[i]);
    end
    random_delays <= delays;
    rst_n         <= 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    assert (!halt && regs == '0 && flags == '0 && pc == `CPU_RESET_PC && !mem_req.arvalid)
      else flag_error("state not cleared by reset");
    rst_n <= 1'b1;
    @(negedge clk);
    assert (mem_req.arvalid && mem_req.araddr == `CPU_RESET_PC)
      else flag_error("first fetch after reset missing or at wrong address");
    while (!halt) begin
      @(negedge clk);
    end
    run_model();
    expect_state("at halt", exp_regs, exp_flags);
    repeat (SETTLE_CYCLES) @(negedge clk);
    assert (!mem_req.arvalid && !mem_req.rready)
      else flag_error("memory port still busy after halt");
    expect_state("after halt", exp_regs, exp_flags);
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == errors_seen) begin
      $display("%-14s ok", name);
    end else begin
      failed_tests++;
      $display("%-14s %0d error(s)", name, errors - errors_seen);
    end
    errors_seen = errors;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_budget) begin
      $display("Watchdog expired after %0d cycles, the core never finished", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    cpu_pkg::reg_view_t zero_regs;
    cpu_pkg::flags_t    zero_flags;

    prog.delete();
    ldi_to(RA, 8'h05);
    prog.push_back(8'h00);
    prog.push_back(8'h00);
    mov_to(RB, RA);
    halt_here();
    run_program(1'b1);
    report_test("reset_fetch");

    prog.delete();
    ldi_to(RA, 8'h12);
    ldi_to(RB, 8'h34);
    mov_to(RC, RA);
    mov_to(RD, RB);
    ldi_to(RA, 8'h80);
    mov_to(RB, RD);
    mov_to(RA, RA);
    halt_here();
    run_program(1'b1);
    report_test("moves");

    build_alu_program();
    run_program(1'b1);
    report_test("alu_flags");

    build_alu_program();
    run_program(1'b0);
    zero_regs  = regs;
    zero_flags = flags;
    run_program(1'b1);
    expect_state("random against zero delays", zero_regs, zero_flags);
    report_test("backpressure");

    // Bytes after halt must stay dead
    prog.delete();
    ldi_to(RA, 8'h11);
    halt_here();
    ldi_to(RA, 8'h77);
    ldi_to(RB, 8'h66);
    run_program(1'b1);
    report_test("halt");

    prog.delete();
    ldi_to(RA, 8'h5A);
    alu_do(cpu_pkg::add, RA, RA);
    prog.push_back(8'h47);
    prog.push_back(8'h5B);
    prog.push_back(8'h6E);
    prog.push_back(8'h71);
    prog.push_back(8'h00);
    halt_here();
    run_program(1'b1);
    report_test("reserved");

    $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/instr_decoder.sv
logic/exec_stage.sv
logic/cpu_top.sv
test/tb_axi_mem.sv
test/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu8

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/alu.sv
      - logic/reg_file.sv
      - logic/fetch_unit.sv
      - logic/instr_decoder.sv
      - logic/exec_stage.sv
      - logic/cpu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_axi_mem.sv
      - test/tb_cpu.sv
